// File: Bender.yml
package:
  name: ppu_background

sources:
  - include_dirs:
      - design
    files:
      - design/ppu_pkg.sv
      - design/ppu_reg_decode.sv
      - design/ppu_timing.sv
      - design/ppu_scroll.sv
      - design/ppu_vram_port.sv
      - design/ppu_color_out.sv
      - design/ppu_top.sv
  - target: simulation
    include_dirs:
      - design
    files:
      - verification/ppu_props.sv
      - verification/ppu_tb.sv

// File: design/ppu_color_out.sv
/* Palette RAM and CPU read path
   Maps background pixels to colors and muxes status, palette and buffered VRAM data */
`timescale 1ns/1ns
`include "ppu_consts.svh"

module ppu_color_out import ppu_pkg::*; (
  input  logic        clk,
  input  logic        reset,
  input  reg_access_s acc,
  input  logic [2:0]  cpu_ain,
  input  reg_data_t   din,
  input  logic        is_rendering,
  input  logic        pal_access,
  input  loopy_t      loopy,
  input  bg_pixel_t   bg_pixel,
  input  mask_s       mask,
  input  reg_data_t   status_byte,
  input  logic        vram_r,
  input  reg_data_t   vram_din,
  output color_t      color,
  output reg_data_t   dout
);

  color_t [0:31] pal_mem;
  pal_addr_t     pal_idx;
  pal_addr_t     pal_rd_idx;  // Entry 0 of every group folds to the backdrop
  color_t        pal_color;
  logic          pal_wr;
  logic          rd_pending;  // VRAM data arrives the cycle after vram_r
  reg_data_t     read_buf;

  always_comb begin
    if (is_rendering) begin
      pal_idx = {1'b0, bg_pixel};
    end else if (pal_access) begin
      pal_idx = loopy[4:0];
    end else begin
      pal_idx = '0;  // Backdrop while idle
    end
  end

  assign pal_rd_idx = (pal_idx[1:0] == 2'b00) ? '0 : pal_idx;
  assign pal_color  = pal_mem[pal_rd_idx];

  // Entries 4, 8 and 12 of each half are not writable
  assign pal_wr = acc.data_wr && pal_access &&
                  !((pal_idx[3:2] != 2'b00) && (pal_idx[1:0] == 2'b00));

  always_ff @(posedge clk) begin
    if (reset) begin
      pal_mem <= `PPU_PALETTE_INIT;
    end else if (pal_wr) begin
      pal_mem[pal_rd_idx] <= din[5:0];
    end
  end

  assign color = mask.grayscale ? {pal_color[5:4], 4'b0000} : pal_color;

  always_ff @(posedge clk) begin
    if (reset) begin
      rd_pending <= 1'b0;
      read_buf   <= '0;
    end else begin
      rd_pending <= vram_r;
      if (rd_pending) read_buf <= vram_din;
    end
  end

  // Palette reads bypass the buffer
  always_comb begin
    if (cpu_ain == `PPU_REG_STATUS) begin
      dout = status_byte;
    end else if (pal_access) begin
      dout = {2'b00, color};
    end else begin
      dout = read_buf;
    end
  end

endmodule

// File: design/ppu_consts.svh
/* Fixed console constants for the picture unit
   Register numbers, line and cycle limits, VRAM address fields and the power-up palette */
`ifndef PPU_CONSTS_SVH
`define PPU_CONSTS_SVH

// CPU register window selected by the low 3 address bits
`define PPU_REG_CTRL      3'd0
`define PPU_REG_MASK      3'd1
`define PPU_REG_STATUS    3'd2
`define PPU_REG_OAM_ADDR  3'd3  // Sprite registers have no effect
`define PPU_REG_OAM_DATA  3'd4
`define PPU_REG_SCROLL    3'd5
`define PPU_REG_ADDR      3'd6
`define PPU_REG_DATA      3'd7

`define PPU_LAST_VISIBLE_LINE  9'd239
`define PPU_VBLANK_START_LINE  9'd240  // Idle line before vblank
`define PPU_VBLANK_END_LINE    9'd260
`define PPU_PRE_RENDER_LINE    9'd511  // Line -1

`define PPU_LAST_CYCLE_GROUP   6'd42   // Cycles 336..343
`define PPU_HSCROLL_COPY_CYCLE 9'd256
`define PPU_VSCROLL_INC_CYCLE  9'd251
`define PPU_VCOPY_CYCLE        9'd304

`define PPU_NAME_TABLE_BASE    2'b10   // 0x2000 region
`define PPU_ATTR_OFFSET        4'b1111 // Attribute block at 0x3C0 in each table
`define PPU_PALETTE_PAGE       6'h3F

`define PPU_PALETTE_INIT { \
  6'h0F, 6'h2C, 6'h10, 6'h1C, 6'h0F, 6'h37, 6'h27, 6'h07, \
  6'h0F, 6'h28, 6'h16, 6'h07, 6'h0F, 6'h28, 6'h0F, 6'h2C, \
  6'h0F, 6'h0F, 6'h2C, 6'h11, 6'h0F, 6'h0F, 6'h20, 6'h38, \
  6'h0F, 6'h0F, 6'h15, 6'h27, 6'h0F, 6'h0F, 6'h11, 6'h3C}

`endif

// File: design/ppu_pkg.sv
/* Shared types for the picture unit RTL
   Width typedefs and the packed bundles passed between the blocks */
package ppu_pkg;

  typedef logic [8:0]  scanline_t;  // 511 is the pre-render line
  typedef logic [8:0]  cycle_t;     // Pixel cycle in the line
  typedef logic [13:0] vram_addr_t;
  typedef logic [14:0] loopy_t;     // Fine Y in bits 14:12
  typedef logic [7:0]  reg_data_t;
  typedef logic [5:0]  color_t;
  typedef logic [4:0]  pal_addr_t;
  typedef logic [3:0]  bg_pixel_t;  // Attribute pair over pattern pair

  // CPU side of the register window
  typedef struct packed {
    logic [2:0] ain;   // Register number
    reg_data_t  din;
    logic       read;
    logic       write;
  } cpu_bus_s;

  // One-cycle register access strobes
  typedef struct packed {
    logic ctrl_wr;
    logic mask_wr;
    logic status_rd;
    logic scroll_wr;
    logic addr_wr;
    logic data_rd;
    logic data_wr;
  } reg_access_s;

  typedef struct packed {
    logic grayscale;
    logic playfield_clip;    // Show background in the left 8 pixels
    logic enable_playfield;
  } mask_s;

  typedef struct packed {
    scanline_t scanline;
    cycle_t    cycle;
    logic      is_pre_render;
    logic      end_of_line;          // Last cycle of the line
    logic      at_last_cycle_group;
    logic      entering_vblank;      // Last cycle of line 240
    logic      exiting_vblank;       // Last cycle of line 260
  } timing_s;

endpackage

// File: design/ppu_reg_decode.sv
/* CPU register decode for the picture unit
   Turns bus cycles into access strobes and keeps control, mask and the vblank flag */
`timescale 1ns/1ns
`include "ppu_consts.svh"

module ppu_reg_decode import ppu_pkg::*; (
  input  logic        clk,
  input  logic        reset,
  input  cpu_bus_s    cpu,
  input  logic        entering_vblank,
  input  logic        exiting_vblank,
  output reg_access_s acc,
  output mask_s       mask,
  output logic        bg_patt,     // Background pattern table select
  output logic        addr_incr,   // Data port steps by 32 when set
  output logic        nmi,
  output reg_data_t   status_byte
);

  logic nmi_enable;   // Control bit 7
  logic vblank_flag;  // Status bit 7

  // Strobes follow the bus in the same cycle
  always_comb begin
    acc.ctrl_wr   = cpu.write && (cpu.ain == `PPU_REG_CTRL);
    acc.mask_wr   = cpu.write && (cpu.ain == `PPU_REG_MASK);
    acc.status_rd = cpu.read  && (cpu.ain == `PPU_REG_STATUS);
    acc.scroll_wr = cpu.write && (cpu.ain == `PPU_REG_SCROLL);
    acc.addr_wr   = cpu.write && (cpu.ain == `PPU_REG_ADDR);
    acc.data_rd   = cpu.read  && (cpu.ain == `PPU_REG_DATA);
    acc.data_wr   = cpu.write && (cpu.ain == `PPU_REG_DATA);
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      bg_patt    <= 1'b0;
      addr_incr  <= 1'b0;
      nmi_enable <= 1'b0;
      mask       <= '0;
    end else begin
      if (acc.ctrl_wr) begin
        addr_incr  <= cpu.din[2];
        bg_patt    <= cpu.din[4];
        nmi_enable <= cpu.din[7];
      end
      if (acc.mask_wr) begin
        mask.grayscale        <= cpu.din[0];
        mask.playfield_clip   <= cpu.din[1];
        mask.enable_playfield <= cpu.din[3];
      end
    end
  end

  // Status read wins over a vblank entry in the same cycle
  always_ff @(posedge clk) begin
    if (reset) begin
      vblank_flag <= 1'b0;
    end else if (acc.status_rd || exiting_vblank) begin
      vblank_flag <= 1'b0;
    end else if (entering_vblank) begin
      vblank_flag <= 1'b1;
    end
  end

  assign nmi         = vblank_flag && nmi_enable;
  assign status_byte = {vblank_flag, 7'b0000000};  // Sprite hit and overflow read as zero

endmodule

// File: design/ppu_scroll.sv
/* Loopy scroll and VRAM address registers
   Current and temporary address, fine X and the shared write latch of scroll and address */
`timescale 1ns/1ns
`include "ppu_consts.svh"

module ppu_scroll import ppu_pkg::*; (
  input  logic        clk,
  input  logic        reset,
  input  reg_access_s acc,
  input  reg_data_t   din,
  input  logic        addr_incr,
  input  timing_s     tm,
  input  logic        is_rendering,
  output loopy_t      loopy,
  output logic [2:0]  fine_x
);

  loopy_t     cur_addr;   // v
  loopy_t     tmp_addr;   // t
  logic [2:0] fine_x_q;
  logic       second_wr;  // Set between first and second write
  cycle_t     cyc;
  logic       coarse_x_step;

  assign cyc = tm.cycle;

  // Step after each attribute fetch, visible part plus the two prefetch tiles
  assign coarse_x_step = (cyc[2:0] == 3'd3) &&
                         ((cyc < `PPU_HSCROLL_COPY_CYCLE) ||
                          ((cyc >= 9'd320) && (cyc < 9'd336)));

  always_ff @(posedge clk) begin
    if (reset) begin
      cur_addr  <= '0;
      tmp_addr  <= '0;
      fine_x_q  <= '0;
      second_wr <= 1'b0;
    end else begin
      if (is_rendering) begin
        if (coarse_x_step) begin
          cur_addr[4:0] <= cur_addr[4:0] + 5'd1;
          cur_addr[10]  <= cur_addr[10] ^ (cur_addr[4:0] == 5'd31);  // Next table
        end
        if (cyc == `PPU_VSCROLL_INC_CYCLE) begin
          cur_addr[14:12] <= cur_addr[14:12] + 3'd1;
          if (cur_addr[14:12] == 3'd7) begin  // Fine Y wraps into coarse Y
            if (cur_addr[9:5] == 5'd29) begin
              cur_addr[9:5] <= 5'd0;
              cur_addr[11]  <= !cur_addr[11];
            end else begin
              cur_addr[9:5] <= cur_addr[9:5] + 5'd1;
            end
          end
        end
        if (cyc == `PPU_HSCROLL_COPY_CYCLE) begin
          {cur_addr[10], cur_addr[4:0]} <= {tmp_addr[10], tmp_addr[4:0]};
        end
        if ((cyc == `PPU_VCOPY_CYCLE) && tm.is_pre_render) begin
          cur_addr <= tmp_addr;  // Whole frame origin
        end
      end
      if (acc.ctrl_wr) begin
        tmp_addr[11:10] <= din[1:0];  // Base name table
      end else if (acc.scroll_wr) begin
        if (!second_wr) begin
          tmp_addr[4:0] <= din[7:3];
          fine_x_q      <= din[2:0];
        end else begin
          tmp_addr[9:5]   <= din[7:3];
          tmp_addr[14:12] <= din[2:0];
        end
        second_wr <= !second_wr;
      end else if (acc.addr_wr) begin
        if (!second_wr) begin
          tmp_addr[13:8] <= din[5:0];
          tmp_addr[14]   <= 1'b0;
        end else begin
          tmp_addr[7:0] <= din;
          cur_addr      <= {tmp_addr[14:8], din};
        end
        second_wr <= !second_wr;
      end else if (acc.status_rd) begin
        second_wr <= 1'b0;
      end else if ((acc.data_rd || acc.data_wr) && !is_rendering) begin
        cur_addr <= cur_addr + (addr_incr ? 15'd32 : 15'd1);
      end
    end
  end

  assign loopy  = cur_addr;
  assign fine_x = fine_x_q;

endmodule

// File: design/ppu_timing.sv
/* Scanline and pixel cycle counters
   Also keeps the vblank level and the odd-frame toggle that shortens the pre-render line */
`timescale 1ns/1ns
`include "ppu_consts.svh"

module ppu_timing import ppu_pkg::*; (
  input  logic    clk,
  input  logic    reset,
  input  logic    enable_playfield,
  output timing_s tm,
  output logic    is_rendering
);

  scanline_t scanline;
  cycle_t    cycle;
  logic      is_in_vblank;
  logic      odd_frame;     // Toggles once per frame
  logic      end_of_line;
  logic      last_group;

  assign last_group = (cycle[8:3] == `PPU_LAST_CYCLE_GROUP);

  // Odd frames drop the last cycle of the pre-render line while rendering
  always_comb begin
    if ((scanline == `PPU_PRE_RENDER_LINE) && odd_frame && is_rendering) begin
      end_of_line = last_group && (cycle[3:0] == 4'd3);  // Cycle 339
    end else begin
      end_of_line = last_group && (cycle[3:0] == 4'd4);  // Cycle 340
    end
  end

  assign is_rendering = enable_playfield && !is_in_vblank &&
                        (scanline != `PPU_VBLANK_START_LINE);

  always_ff @(posedge clk) begin
    if (reset) begin
      cycle        <= '0;
      scanline     <= '0;
      is_in_vblank <= 1'b1;
      odd_frame    <= 1'b0;
    end else begin
      cycle <= end_of_line ? '0 : cycle + 9'd1;
      if (tm.entering_vblank) is_in_vblank <= 1'b1;
      else if (tm.exiting_vblank) is_in_vblank <= 1'b0;
      if (end_of_line) begin
        // 260 wraps to line -1, and -1 rolls over to 0
        scanline <= tm.exiting_vblank ? `PPU_PRE_RENDER_LINE : scanline + 9'd1;
      end
      if (tm.exiting_vblank) odd_frame <= !odd_frame;
    end
  end

  always_comb begin
    tm.scanline            = scanline;
    tm.cycle               = cycle;
    tm.is_pre_render       = (scanline == `PPU_PRE_RENDER_LINE);
    tm.end_of_line         = end_of_line;
    tm.at_last_cycle_group = last_group;
    tm.entering_vblank     = end_of_line && (scanline == `PPU_VBLANK_START_LINE);
    tm.exiting_vblank      = end_of_line && (scanline == `PPU_VBLANK_END_LINE);
  end

endmodule

// File: design/ppu_top.sv
/* Background picture unit top level
   One pixel per clock, CPU register window on one side and the VRAM bus on the other */
`timescale 1ns/1ns

module ppu_top (
  input  logic                 clk,
  input  logic                 reset,
  input  ppu_pkg::cpu_bus_s    cpu,
  input  ppu_pkg::reg_data_t   vram_din,
  output ppu_pkg::color_t      color,
  output ppu_pkg::reg_data_t   dout,
  output logic                 nmi,
  output logic                 vram_r,
  output logic                 vram_w,
  output ppu_pkg::vram_addr_t  vram_a,
  output ppu_pkg::reg_data_t   vram_dout,
  output ppu_pkg::scanline_t   scanline,
  output ppu_pkg::cycle_t      cycle
);

  ppu_pkg::reg_access_s acc;
  ppu_pkg::mask_s       mask;
  ppu_pkg::timing_s     tm;
  ppu_pkg::reg_data_t   status_byte;
  ppu_pkg::loopy_t      loopy;
  ppu_pkg::bg_pixel_t   bg_pixel;
  logic                 bg_patt;
  logic                 addr_incr;
  logic                 is_rendering;
  logic [2:0]           fine_x;
  logic                 pal_access;  // Loopy address in the palette page

  ppu_reg_decode u_decode (.clk, .reset, .cpu, .entering_vblank(tm.entering_vblank),
                           .exiting_vblank(tm.exiting_vblank), .acc, .mask, .bg_patt,
                           .addr_incr, .nmi, .status_byte);

  ppu_timing u_timing (.clk, .reset, .enable_playfield(mask.enable_playfield), .tm,
                       .is_rendering);

  ppu_scroll u_scroll (.clk, .reset, .acc, .din(cpu.din), .addr_incr, .tm, .is_rendering,
                       .loopy, .fine_x);

  ppu_vram_port u_vram (.clk, .reset, .acc, .tm, .is_rendering, .loopy, .fine_x, .bg_patt,
                        .mask, .vram_din, .vram_a, .vram_r, .vram_w, .pal_access, .bg_pixel);

  ppu_color_out u_color (.clk, .reset, .acc, .cpu_ain(cpu.ain), .din(cpu.din), .is_rendering,
                         .pal_access, .loopy, .bg_pixel, .mask, .status_byte, .vram_r,
                         .vram_din, .color, .dout);

  assign vram_dout = cpu.din;  // CPU data goes straight to the VRAM bus
  assign scanline  = tm.scanline;
  assign cycle     = tm.cycle;

endmodule

// File: design/ppu_vram_port.sv
/* Background fetch pipeline and VRAM bus control
   Fetches name, attribute and pattern bytes per tile and shifts them out by fine X */
`timescale 1ns/1ns
`include "ppu_consts.svh"

module ppu_vram_port import ppu_pkg::*; (
  input  logic        clk,
  input  logic        reset,
  input  reg_access_s acc,
  input  timing_s     tm,
  input  logic        is_rendering,
  input  loopy_t      loopy,
  input  logic [2:0]  fine_x,
  input  logic        bg_patt,
  input  mask_s       mask,
  input  reg_data_t   vram_din,
  output vram_addr_t  vram_a,
  output logic        vram_r,
  output logic        vram_w,
  output logic        pal_access,
  output bg_pixel_t   bg_pixel
);

  logic [15:0] patt_lo_pipe;  // Pattern plane 0
  logic [15:0] patt_hi_pipe;  // Pattern plane 1
  logic [8:0]  attr_lo_pipe;
  logic [8:0]  attr_hi_pipe;
  reg_data_t   name_byte;
  logic [1:0]  attr_bits;     // Quadrant of the attribute byte
  reg_data_t   patt_lo;
  logic [1:0]  attr_sel;
  logic [3:0]  pipe_idx;
  bg_pixel_t   raw_pixel;
  logic        show_bg;

  // Leftmost pixel sits in bit 0 of the pipes
  function automatic reg_data_t bit_rev(input reg_data_t b);
    reg_data_t r;
    for (int i = 0; i < 8; i++) r[i] = b[7 - i];
    return r;
  endfunction

  assign attr_sel = {loopy[6], loopy[1]};  // Coarse Y bit 1, coarse X bit 1

  always_ff @(posedge clk) begin
    if (reset) begin
      name_byte    <= '0;
      attr_bits    <= '0;
      patt_lo      <= '0;
      patt_lo_pipe <= '0;
      patt_hi_pipe <= '0;
      attr_lo_pipe <= '0;
      attr_hi_pipe <= '0;
    end else begin
      case (tm.cycle[2:0])
        3'd1: name_byte <= vram_din;
        3'd3: attr_bits <= vram_din[{attr_sel, 1'b0} +: 2];
        3'd5: patt_lo   <= vram_din;
        default: ;  // Plane 1 goes straight into the pipe at cycle 7
      endcase
      if (!tm.at_last_cycle_group) begin
        patt_lo_pipe[14:0] <= patt_lo_pipe[15:1];
        patt_hi_pipe[14:0] <= patt_hi_pipe[15:1];
        attr_lo_pipe[7:0]  <= attr_lo_pipe[8:1];
        attr_hi_pipe[7:0]  <= attr_hi_pipe[8:1];
        if (tm.cycle[2:0] == 3'd7) begin
          patt_lo_pipe[15:8] <= bit_rev(patt_lo);
          patt_hi_pipe[15:8] <= bit_rev(vram_din);
          attr_lo_pipe[8]    <= attr_bits[0];
          attr_hi_pipe[8]    <= attr_bits[1];
        end
      end
    end
  end

  assign pipe_idx  = {1'b0, fine_x};
  assign raw_pixel = {attr_hi_pipe[pipe_idx], attr_lo_pipe[pipe_idx],
                      patt_hi_pipe[pipe_idx], patt_lo_pipe[pipe_idx]};
  assign show_bg   = (mask.playfield_clip || (tm.cycle[7:3] != 5'd0)) && mask.enable_playfield;
  assign bg_pixel  = {raw_pixel[3:2], show_bg ? raw_pixel[1:0] : 2'b00};

  assign pal_access = (loopy[13:8] == `PPU_PALETTE_PAGE);

  // Fetch slot decides the address while rendering
  always_comb begin
    if (!is_rendering) begin
      vram_a = loopy[13:0];
    end else if (tm.cycle[2:1] == 2'd0) begin
      vram_a = {`PPU_NAME_TABLE_BASE, loopy[11:0]};  // Name byte
    end else if (tm.cycle[2:1] == 2'd1) begin
      vram_a = {`PPU_NAME_TABLE_BASE, loopy[11:10], `PPU_ATTR_OFFSET,
                loopy[9:7], loopy[4:2]};              // Attribute byte
    end else begin
      vram_a = {1'b0, bg_patt, name_byte, tm.cycle[1], loopy[14:12]};  // Pattern planes
    end
  end

  assign vram_r = acc.data_rd || (is_rendering && !tm.cycle[0] && !tm.end_of_line);
  assign vram_w = acc.data_wr && !pal_access && !is_rendering;

endmodule

// File: project.f
+incdir+design
design/ppu_pkg.sv
design/ppu_reg_decode.sv
design/ppu_timing.sv
design/ppu_scroll.sv
design/ppu_vram_port.sv
design/ppu_color_out.sv
design/ppu_top.sv
verification/ppu_props.sv
verification/ppu_tb.sv

// File: verification/ppu_props.sv
/* Bound checks for the picture unit top level
   Tracks register writes in small shadow models and asserts the timing, bus and palette rules */
`timescale 1ns/1ns
`include "ppu_consts.svh"

module ppu_props import ppu_pkg::*; (
  input logic       clk,
  input logic       reset,
  input cpu_bus_s   cpu,
  input reg_data_t  vram_din,
  input color_t     color,
  input reg_data_t  dout,
  input logic       nmi,
  input logic       vram_r,
  input logic       vram_w,
  input vram_addr_t vram_a,
  input reg_data_t  vram_dout,
  input scanline_t  scanline,
  input cycle_t     cycle,
  input loopy_t     loopy
);

  int               fail_count = 0;  // Read by the testbench at the end
  logic             pf_on;
  logic             gray;
  logic             nmi_en;
  logic             incr_32;
  logic             in_vblank;       // High from reset until the first line 260 ends
  logic             addr_latch;      // Second write of the pair is next
  logic [5:0]       addr_hi;
  vram_addr_t       exp_addr;        // Expected data port address
  logic [0:31][5:0] pal_model;
  logic             status_rd, data_rd, data_wr;
  logic             vblank_in, vblank_out, render_m, exp_pal, pal_locked;
  pal_addr_t        pal_idx;
  pal_addr_t        pal_fold;        // Group entry 0 maps to the backdrop
  color_t           exp_color;
  color_t           backdrop;        // Shown while idle outside the palette page

  assign status_rd  = cpu.read && (cpu.ain == `PPU_REG_STATUS);
  assign data_rd    = cpu.read && (cpu.ain == `PPU_REG_DATA);
  assign data_wr    = cpu.write && (cpu.ain == `PPU_REG_DATA);
  assign vblank_in  = (scanline == `PPU_VBLANK_START_LINE) && (cycle == 9'd340);
  assign vblank_out = (scanline == `PPU_VBLANK_END_LINE) && (cycle == 9'd340);
  assign render_m   = pf_on && !in_vblank && (scanline != `PPU_VBLANK_START_LINE);
  assign exp_pal    = (exp_addr[13:8] == `PPU_PALETTE_PAGE);
  assign pal_idx    = exp_addr[4:0];
  assign pal_fold   = (pal_idx[1:0] == 2'b00) ? 5'd0 : pal_idx;
  assign pal_locked = (pal_idx[3:2] != 2'b00) && (pal_idx[1:0] == 2'b00);  // 4, 8, 12
  assign exp_color  = gray ? {pal_model[pal_fold][5:4], 4'b0000} : pal_model[pal_fold];
  assign backdrop   = gray ? {pal_model[0][5:4], 4'b0000} : pal_model[0];

  always_ff @(posedge clk) begin
    if (reset) begin
      pf_on      <= 1'b0;
      gray       <= 1'b0;
      nmi_en     <= 1'b0;
      incr_32    <= 1'b0;
      in_vblank  <= 1'b1;
      addr_latch <= 1'b0;
      addr_hi    <= '0;
      exp_addr   <= '0;
      pal_model  <= `PPU_PALETTE_INIT;
    end else begin
      if (cpu.write && (cpu.ain == `PPU_REG_CTRL)) begin
        nmi_en  <= cpu.din[7];
        incr_32 <= cpu.din[2];
      end
      if (cpu.write && (cpu.ain == `PPU_REG_MASK)) begin
        pf_on <= cpu.din[3];
        gray  <= cpu.din[0];
      end
      if (vblank_in) in_vblank <= 1'b1;
      else if (vblank_out) in_vblank <= 1'b0;
      // Scroll and address share one latch
      if (status_rd) addr_latch <= 1'b0;
      else if (cpu.write && (cpu.ain == `PPU_REG_SCROLL || cpu.ain == `PPU_REG_ADDR))
        addr_latch <= !addr_latch;
      if (cpu.write && (cpu.ain == `PPU_REG_ADDR)) begin
        if (!addr_latch) addr_hi <= cpu.din[5:0];
        else exp_addr <= {addr_hi, cpu.din};
      end else if ((data_rd || data_wr) && !render_m) begin
        exp_addr <= exp_addr + (incr_32 ? 14'd32 : 14'd1);
      end
      if (data_wr && exp_pal && !pal_locked) pal_model[pal_fold] <= cpu.din[5:0];
    end
  end

  task automatic note_failure(input string msg);
    fail_count++;
    $error("Fail at %0t: %s", $time, msg);
  endtask

  a_reset_state: assert property (@(posedge clk) $fell(reset) |->
      !nmi && (cycle == 9'd0) && (scanline == 9'd0)) else note_failure("state after reset");
  a_idle_bus: assert property (@(posedge clk) disable iff (reset)
      !cpu.read && !cpu.write && !render_m |-> !vram_r && !vram_w)
    else note_failure("VRAM strobe while idle");
  a_cycle_step: assert property (@(posedge clk) disable iff (reset)
      (cycle < 9'd339) || ((cycle == 9'd339) && (scanline != `PPU_PRE_RENDER_LINE)) |=>
      cycle == $past(cycle) + 9'd1) else note_failure("cycle did not advance");
  a_cycle_wrap: assert property (@(posedge clk) disable iff (reset)
      cycle == 9'd340 |=> cycle == 9'd0) else note_failure("cycle did not wrap after 340");
  a_line_step: assert property (@(posedge clk) disable iff (reset)
      (cycle == 9'd340) && (scanline < `PPU_VBLANK_END_LINE) |=>
      scanline == $past(scanline) + 9'd1) else note_failure("scanline did not step");
  a_line_260: assert property (@(posedge clk) disable iff (reset)
      vblank_out |=> scanline == `PPU_PRE_RENDER_LINE) else note_failure("260 not followed by 511");
  a_line_511: assert property (@(posedge clk) disable iff (reset)
      (scanline == `PPU_PRE_RENDER_LINE) ##1 (scanline != `PPU_PRE_RENDER_LINE) |->
      scanline == 9'd0) else note_failure("511 not followed by 0");
  a_nmi_rise: assert property (@(posedge clk) disable iff (reset)
      vblank_in && nmi_en && !status_rd |=> nmi) else note_failure("nmi missing after line 240");
  a_nmi_edge: assert property (@(posedge clk) disable iff (reset)
      $rose(nmi) |-> $past(vblank_in)) else note_failure("nmi rose at the wrong cycle");
  a_status_rd: assert property (@(posedge clk) disable iff (reset)
      status_rd && nmi |-> dout[7] ##1 !nmi) else note_failure("status read vs vblank flag");
  a_nmi_fall: assert property (@(posedge clk) disable iff (reset)
      vblank_out |=> !nmi) else note_failure("nmi still high after line 260");
  a_vram_write: assert property (@(posedge clk) disable iff (reset)
      data_wr && !exp_pal && !render_m |-> vram_w && (vram_a == exp_addr) &&
      (vram_dout == cpu.din)) else note_failure("VRAM write address or data");
  a_vram_read: assert property (@(posedge clk) disable iff (reset)
      data_rd && !render_m |-> vram_r && (vram_a == exp_addr)) else note_failure("VRAM read address");
  a_read_buffer: assert property (@(posedge clk) disable iff (reset)
      data_rd && !exp_pal && !render_m ##1 1'b1 |=>
      (cpu.ain == `PPU_REG_STATUS) || exp_pal || (dout == $past(vram_din)))
    else note_failure("buffered read data");
  a_pal_no_write: assert property (@(posedge clk) disable iff (reset)
      data_wr && exp_pal |-> !vram_w) else note_failure("vram_w on palette write");
  a_pal_read: assert property (@(posedge clk) disable iff (reset)
      data_rd && exp_pal && !render_m |-> dout == {2'b00, exp_color})
    else note_failure("palette read value");
  a_idle_color: assert property (@(posedge clk) disable iff (reset)
      !render_m |-> color == (exp_pal ? exp_color : backdrop))
    else note_failure("color output while idle");
  a_fetch_rd: assert property (@(posedge clk) disable iff (reset)
      render_m && (scanline <= `PPU_LAST_VISIBLE_LINE) && !cycle[0] && (cycle != 9'd340) |->
      vram_r) else note_failure("missing fetch read on even cycle");
  a_fetch_idle: assert property (@(posedge clk) disable iff (reset)
      render_m && (scanline <= `PPU_LAST_VISIBLE_LINE) && cycle[0] && !cpu.read |->
      !vram_r) else note_failure("fetch read on odd cycle");
  a_name_addr: assert property (@(posedge clk) disable iff (reset)
      render_m && (scanline <= `PPU_LAST_VISIBLE_LINE) && (cycle[2:1] == 2'b00) |->
      vram_a == {2'b10, loopy[11:0]}) else note_failure("name fetch address");

endmodule

bind ppu_top ppu_props props0 (
  .clk(clk), .reset(reset), .cpu(cpu), .vram_din(vram_din), .color(color), .dout(dout),
  .nmi(nmi), .vram_r(vram_r), .vram_w(vram_w), .vram_a(vram_a), .vram_dout(vram_dout),
  .scanline(scanline), .cycle(cycle), .loopy(loopy)
);

// File: verification/ppu_tb.sv
/* Testbench for the background picture unit
   Drives register, VRAM, palette and rendering sequences; the bound property module checks */
`timescale 1ns/1ns

module ppu_tb import ppu_pkg::*; ();

  localparam int TIMEOUT_CYCLES = 2 * 262 * 341 + 4000;  // Two frames plus slack
  localparam logic [2:0] REG_CTRL   = 3'd0;
  localparam logic [2:0] REG_MASK   = 3'd1;
  localparam logic [2:0] REG_STATUS = 3'd2;
  localparam logic [2:0] REG_ADDR   = 3'd6;
  localparam logic [2:0] REG_DATA   = 3'd7;
  localparam cpu_bus_s   BUS_IDLE   = '{ain: 3'd7, din: 8'h00, read: 1'b0, write: 1'b0};

  logic       clk;
  logic       reset;
  cpu_bus_s   cpu;
  reg_data_t  vram_din;
  color_t     color;
  reg_data_t  dout;
  logic       nmi;
  logic       vram_r;
  logic       vram_w;
  vram_addr_t vram_a;
  reg_data_t  vram_dout;
  scanline_t  scanline;
  cycle_t     cycle;
  int         seed = 22;
  int         cycle_count = 0;
  int         tests_run = 0;
  int         fails_seen = 0;
  logic [5:0] pal_vals [0:2];  // Random palette entries

  ppu_top dut0 (.clk, .reset, .cpu, .vram_din, .color, .dout, .nmi, .vram_r, .vram_w,
                .vram_a, .vram_dout, .scanline, .cycle);

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  always @(posedge clk) vram_din <= reg_data_t'($random(seed));  // Fresh VRAM byte each cycle

  // Run limit
  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("Timeout: run did not end within %0d cycles", TIMEOUT_CYCLES);
      $display("Test failed");
      $finish;
    end
  end

  // One bus cycle, then back to idle
  task automatic bus_access(input logic [2:0] ain, input reg_data_t data, input logic is_wr);
    @(posedge clk);
    cpu <= '{ain: ain, din: data, read: !is_wr, write: is_wr};
    @(posedge clk);
    cpu <= BUS_IDLE;
  endtask

  task automatic write_reg(input logic [2:0] ain, input reg_data_t data);
    bus_access(ain, data, 1'b1);
  endtask

  task automatic read_reg(input logic [2:0] ain);
    bus_access(ain, 8'h00, 1'b0);
  endtask

  task automatic set_vram_addr(input vram_addr_t addr);
    write_reg(REG_ADDR, {2'b00, addr[13:8]});
    write_reg(REG_ADDR, addr[7:0]);
  endtask

  task automatic wait_line(input scanline_t line);
    do @(negedge clk); while (scanline != line);
  endtask

  task automatic wait_nmi();
    do @(negedge clk); while (!nmi);
  endtask

  task automatic end_test(input string name);
    int total;
    total = dut0.props0.fail_count;
    tests_run++;
    $display("%0t: %s finished, %0d new assertion failures", $time, name, total - fails_seen);
    fails_seen = total;
  endtask

  initial begin
    reset = 1'b1;
    cpu = BUS_IDLE;
    vram_din = 8'h00;
    for (int i = 0; i < 3; i++) pal_vals[i] = 6'($random(seed));
    repeat (16) @(posedge clk);
    reset <= 1'b0;

    repeat (20) @(negedge clk);
    end_test("reset idle");

    write_reg(REG_CTRL, 8'h80);  // NMI enable
    wait_nmi();
    repeat (3) @(negedge clk);
    read_reg(REG_STATUS);        // Flag read back, nmi drops
    repeat (3) @(negedge clk);
    end_test("vblank nmi with status read");

    set_vram_addr(14'h0123);
    write_reg(REG_DATA, 8'hA5);
    write_reg(REG_DATA, 8'h5A);
    write_reg(REG_CTRL, 8'h84);  // Step by 32
    write_reg(REG_DATA, 8'h3C);
    write_reg(REG_DATA, 8'hC3);
    write_reg(REG_CTRL, 8'h80);
    set_vram_addr(14'h0200);
    repeat (3) read_reg(REG_DATA);
    repeat (3) @(negedge clk);
    end_test("vram write and buffered read");

    set_vram_addr(14'h3F05);
    write_reg(REG_DATA, {2'b00, pal_vals[0]});
    set_vram_addr(14'h3F05);
    read_reg(REG_DATA);
    write_reg(REG_MASK, 8'h01);  // Grayscale
    set_vram_addr(14'h3F05);
    read_reg(REG_DATA);
    write_reg(REG_MASK, 8'h00);
    set_vram_addr(14'h3F10);     // Mirrors the backdrop
    write_reg(REG_DATA, {2'b00, pal_vals[1]});
    set_vram_addr(14'h3F14);     // Locked entry
    write_reg(REG_DATA, {2'b00, pal_vals[2]});
    set_vram_addr(14'h3F00);
    repeat (5) read_reg(REG_DATA);
    set_vram_addr(14'h3F10);
    repeat (5) read_reg(REG_DATA);
    end_test("palette access");

    wait_line(9'd511);
    wait_line(9'd0);
    end_test("line and cycle wrap");

    wait_nmi();
    wait_line(9'd511);           // nmi gone without a status read
    repeat (2) @(negedge clk);
    end_test("vblank nmi without read");

    write_reg(REG_MASK, 8'h0A);  // Playfield on, left column shown
    wait_line(9'd0);
    wait_line(9'd2);
    end_test("background fetch");

    repeat (2) @(negedge clk);
    fails_seen = dut0.props0.fail_count;
    $display("Tests run: %0d, assertion failures: %0d", tests_run, fails_seen);
    if (fails_seen == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule
